// File: verilog/lsq_pkg.sv
// queue parameters, load/store opcode enum, core request, entry and result structs
package lsq_pkg;

  localparam int LSQ_DEPTH = 16;  // queue entries
  localparam int LSQ_ID_W  = 4;   // entry index width
  localparam int DATA_W    = 32;  // data and address width
  localparam int TAG_W     = 4;   // dest reg tag
  localparam int OFFS_W    = 16;  // signed address offset

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } ls_op_e;

  // request from the core
  typedef struct packed {
    ls_op_e              op;
    logic [DATA_W-1:0]   base;
    logic [OFFS_W-1:0]   offset;  // sign extended by decode
    logic [DATA_W-1:0]   data;    // store data, ignored on loads
    logic [TAG_W-1:0]    tag;
  } ls_req_t;

  // one queue slot after decode
  typedef struct packed {
    ls_op_e              op;
    logic [DATA_W-1:0]   addr;    // effective byte address
    logic [DATA_W-1:0]   data;
    logic [TAG_W-1:0]    tag;
  } ls_entry_t;

  // result to the core
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [TAG_W-1:0]    tag;
  } ls_rsp_t;

endpackage

// File: verilog/mem_pkg.sv
// data memory parameters, memory request and response structs
package mem_pkg;

  import lsq_pkg::*;

  localparam int MEM_WORDS   = 1024;
  localparam int MEM_AW      = $clog2(MEM_WORDS);  // word index bits
  localparam int MEM_LATENCY = 2;                  // cycles, read and write alike

  typedef struct packed {
    logic                we;    // 1 = store
    logic [DATA_W-1:0]   addr;  // byte addr, word picked from bits 11:2
    logic [DATA_W-1:0]   data;
    logic [LSQ_ID_W-1:0] id;    // owning queue entry
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [LSQ_ID_W-1:0] id;
  } mem_rsp_t;

endpackage

// File: verilog/lsq_decode.sv
// request stage, core handshake and effective address computation
module lsq_decode import lsq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // core request channel
  input  logic      i_req_valid,
  input  ls_req_t   i_req,
  output logic      o_req_ready,
  // to queue
  input  logic      i_slot_free,  // room for the staged entry plus one more
  output logic      o_ent_valid,
  output ls_entry_t o_ent
);

  logic              accept;
  logic              ent_valid_q;   // stage occupancy
  ls_entry_t         ent_q;
  logic [DATA_W-1:0] offset_sext;
  logic [DATA_W-1:0] eff_addr;

  // the queue already counts a staged entry in i_slot_free,
  // so a full stage only blocks when the queue is about to fill
  assign o_req_ready = i_slot_free;
  assign accept      = i_req_valid && o_req_ready;

  assign offset_sext = {{(DATA_W - OFFS_W){i_req.offset[OFFS_W-1]}}, i_req.offset};
  assign eff_addr    = i_req.base + offset_sext;  // wraps mod 2^32

  // stage valid, one pulse per accepted request
  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid_q <= 1'b0;
    end else begin
      ent_valid_q <= accept;  // queue always takes it next cycle
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (accept) begin
      ent_q.op   <= i_req.op;
      ent_q.addr <= eff_addr;
      ent_q.data <= i_req.data;  // don't care for loads
      ent_q.tag  <= i_req.tag;
    end
  end

  assign o_ent_valid = ent_valid_q;
  assign o_ent       = ent_q;

  // core must hold a stalled request unchanged
  a_req_stable : assert property (
    @(posedge clk) disable iff (rst)
    i_req_valid && !o_req_ready |=> i_req_valid && $stable(i_req)
  ) else $error("lsq_decode: request dropped or changed while stalled");

endmodule

// File: verilog/lsq_queue.sv
// circular entry queue with store-to-load forwarding, memory issue and response capture
module lsq_queue import lsq_pkg::*, mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // from decode
  input  logic      i_ent_valid,
  input  ls_entry_t i_ent,
  output logic      o_slot_free,
  // memory side
  output logic      o_mem_valid,
  output mem_req_t  o_mem_req,
  input  logic      i_mem_valid,
  input  mem_rsp_t  i_mem_rsp,
  // to retire
  output logic      o_head_ready,
  output ls_rsp_t   o_head,
  input  logic      i_pop
);

  ls_entry_t           ent_q [LSQ_DEPTH];      // payload per slot
  logic [LSQ_DEPTH-1:0] rdy_q;                 // result available
  logic [LSQ_ID_W-1:0] head_q;
  logic [LSQ_ID_W-1:0] tail_q;
  logic [LSQ_ID_W:0]   count_q;                // 0..LSQ_DEPTH

  logic                fwd_hit;
  logic [DATA_W-1:0]   fwd_data;
  logic [LSQ_ID_W-1:0] scan_idx;
  logic                fwd;
  ls_entry_t           alloc_ent;

  // scan oldest to youngest, last hit wins so the youngest store supplies the data
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_data = '0;
    scan_idx = head_q;
    for (int k = 0; k < LSQ_DEPTH; k++) begin
      scan_idx = head_q + LSQ_ID_W'(k);
      if ((k < count_q) && (ent_q[scan_idx].op == OP_STORE) &&
          (ent_q[scan_idx].addr == i_ent.addr)) begin
        fwd_hit  = 1'b1;
        fwd_data = ent_q[scan_idx].data;
      end
    end
  end

  assign fwd = i_ent_valid && (i_ent.op == OP_LOAD) && fwd_hit;

  always_comb begin
    alloc_ent = i_ent;
    if (fwd) begin
      alloc_ent.data = fwd_data;
    end
  end

  // issue in the alloc cycle, everything but a forwarded load
  assign o_mem_valid   = i_ent_valid && !fwd;
  assign o_mem_req.we   = (i_ent.op == OP_STORE);
  assign o_mem_req.addr = i_ent.addr;
  assign o_mem_req.data = i_ent.data;
  assign o_mem_req.id   = tail_q;

  // staged entry in decode lands next cycle, keep room for it
  assign o_slot_free = i_ent_valid ? (count_q < LSQ_DEPTH - 1) : (count_q < LSQ_DEPTH);

  assign o_head_ready = (count_q != '0) && rdy_q[head_q];
  assign o_head.data  = ent_q[head_q].data;
  assign o_head.tag   = ent_q[head_q].tag;

  // pointers, count, ready bits
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      rdy_q   <= '0;
    end else begin
      if (i_ent_valid) begin
        rdy_q[tail_q] <= fwd;  // forwarded load done at once
        tail_q        <= tail_q + 1'b1;  // depth is a power of two
      end
      if (i_mem_valid) begin
        rdy_q[i_mem_rsp.id] <= 1'b1;
      end
      if (i_pop) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + (LSQ_ID_W + 1)'(i_ent_valid) - (LSQ_ID_W + 1)'(i_pop);
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (i_ent_valid) begin
      ent_q[tail_q] <= alloc_ent;
    end
    // stores keep their own data for the result
    if (i_mem_valid && (ent_q[i_mem_rsp.id].op == OP_LOAD)) begin
      ent_q[i_mem_rsp.id].data <= i_mem_rsp.data;
    end
  end

  // decode must never push into a full queue
  a_no_overflow : assert property (
    @(posedge clk) disable iff (rst)
    i_ent_valid |-> (count_q < LSQ_DEPTH)
  ) else $error("lsq_queue: allocation while full");

  a_no_underflow : assert property (
    @(posedge clk) disable iff (rst)
    i_pop |-> (count_q != '0)
  ) else $error("lsq_queue: pop while empty");

endmodule

// File: verilog/lsq_retire.sv
// in-order result register toward the core with valid/ready back-pressure
module lsq_retire import lsq_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // queue head
  input  logic    i_head_ready,
  input  ls_rsp_t i_head,
  output logic    o_pop,
  // core result channel
  output logic    o_rsp_valid,
  output ls_rsp_t o_rsp,
  input  logic    i_rsp_ready
);

  logic    out_valid_q;
  ls_rsp_t out_q;
  logic    load;

  // take the head when the register is free or drains this cycle
  assign load  = i_head_ready && (!out_valid_q || i_rsp_ready);
  assign o_pop = load;  // one pop per loaded result

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q <= 1'b0;
    end else if (load) begin
      out_valid_q <= 1'b1;
    end else if (i_rsp_ready) begin
      out_valid_q <= 1'b0;  // drained, nothing behind it
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (load) begin
      out_q <= i_head;
    end
  end

  assign o_rsp_valid = out_valid_q;
  assign o_rsp       = out_q;

  // a ready head waits in place until it is popped
  a_head_held : assert property (
    @(posedge clk) disable iff (rst)
    i_head_ready && !o_pop |=> i_head_ready && $stable(i_head)
  ) else $error("lsq_retire: queue head changed before it was popped");

endmodule

// File: verilog/dcache_model.sv
// data memory model, 1024 words with fixed-latency response delay line
module dcache_model import lsq_pkg::*, mem_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     i_mem_valid,
  input  mem_req_t i_mem_req,
  output logic     o_mem_valid,
  output mem_rsp_t o_mem_rsp
);

  logic [DATA_W-1:0]      mem_q [MEM_WORDS];
  logic [MEM_AW-1:0]      word_idx;
  logic [MEM_LATENCY-1:0] dly_valid_q;          // valid per delay stage
  mem_rsp_t               dly_rsp_q [MEM_LATENCY];
  mem_rsp_t               rsp_in;

  assign word_idx = i_mem_req.addr[MEM_AW+1:2];  // word aligned

  // reads see the old word, stores echo their data
  assign rsp_in.data = i_mem_req.we ? i_mem_req.data : mem_q[word_idx];
  assign rsp_in.id   = i_mem_req.id;

  // storage, each word holds its index after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= DATA_W'(i);
      end
    end else if (i_mem_valid && i_mem_req.we) begin
      mem_q[word_idx] <= i_mem_req.data;
    end
  end

  // delay line valids
  always_ff @(posedge clk) begin
    if (rst) begin
      dly_valid_q <= '0;
    end else begin
      dly_valid_q[0] <= i_mem_valid;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        dly_valid_q[i] <= dly_valid_q[i-1];
      end
    end
  end

  // delay line payload
  always_ff @(posedge clk) begin
    dly_rsp_q[0] <= rsp_in;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      dly_rsp_q[i] <= dly_rsp_q[i-1];
    end
  end

  assign o_mem_valid = dly_valid_q[MEM_LATENCY-1];
  assign o_mem_rsp   = dly_rsp_q[MEM_LATENCY-1];

endmodule

// File: verilog/lsq_top.sv
// load/store queue subsystem, decode, queue, retire and data memory
module lsq_top import lsq_pkg::*, mem_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  // core request
  input  logic    i_req_valid,
  input  ls_req_t i_req,
  output logic    o_req_ready,
  // core result
  output logic    o_rsp_valid,
  output ls_rsp_t o_rsp,
  input  logic    i_rsp_ready
);

  logic      slot_free;
  logic      ent_valid;
  ls_entry_t ent;
  logic      mreq_valid;   // queue -> memory
  mem_req_t  mreq;
  logic      mrsp_valid;   // memory -> queue
  mem_rsp_t  mrsp;
  logic      head_ready;
  ls_rsp_t   head;
  logic      pop;

  lsq_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .i_slot_free (slot_free),
    .o_ent_valid (ent_valid),
    .o_ent       (ent)
  );

  lsq_queue queue_i (
    .clk          (clk),
    .rst          (rst),
    .i_ent_valid  (ent_valid),
    .i_ent        (ent),
    .o_slot_free  (slot_free),
    .o_mem_valid  (mreq_valid),
    .o_mem_req    (mreq),
    .i_mem_valid  (mrsp_valid),
    .i_mem_rsp    (mrsp),
    .o_head_ready (head_ready),
    .o_head       (head),
    .i_pop        (pop)
  );

  lsq_retire retire_i (
    .clk          (clk),
    .rst          (rst),
    .i_head_ready (head_ready),
    .i_head       (head),
    .o_pop        (pop),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .i_rsp_ready  (i_rsp_ready)
  );

  dcache_model dcache_i (
    .clk         (clk),
    .rst         (rst),
    .i_mem_valid (mreq_valid),
    .i_mem_req   (mreq),
    .o_mem_valid (mrsp_valid),
    .o_mem_rsp   (mrsp)
  );

endmodule

// File: test/tb_clock.sv
// testbench clock and synchronous reset generator
module tb_clock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // release on a falling edge, clear of the DUT's sampling edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: test/lsq_tb.sv
// testbench top, directed LSQ tests against a word model, LFSR stimulus, timeout, report
module lsq_tb import lsq_pkg::*, mem_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] SEED = 32'hb13efab8;
  localparam int MAX_CYCLES = 4000;  // 234 requests, each far below 17 cycles worst case
  localparam int GAP_LEN    = 256;
  localparam int RSP_ON     = 0;
  localparam int RSP_OFF    = 1;
  localparam int RSP_GAP    = 2;

  logic        clk;
  logic        rst;
  logic        i_req_valid;
  ls_req_t     i_req;
  logic        o_req_ready;
  logic        o_rsp_valid;
  ls_rsp_t     o_rsp;
  logic        i_rsp_ready;
  logic [31:0] model_mem [MEM_WORDS];  // expected memory image
  ls_rsp_t     exp_q [$];              // expected results, request order
  ls_rsp_t     got_q [$];              // results seen on the core side
  logic        gap_pat [GAP_LEN];      // result ready pattern
  logic [31:0] lfsr_q;
  int          rsp_mode;
  int          gap_idx;
  int          cycles;
  int          test_errs;
  int          total_errs;
  int          total_checks;
  int          tests_run;

  tb_clock clock_i (.clk(clk), .rst(rst));

  lsq_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // random offset, base chosen so the effective address hits the word
  function automatic ls_req_t make_req(input ls_op_e op, input int word,
                                       input logic [31:0] data, input logic [3:0] tag);
    ls_req_t r;
    r.op     = op;
    r.offset = 16'(rand_bits(16)) & 16'hfffc;  // word aligned
    r.base   = 32'(word * 4) - {{16{r.offset[15]}}, r.offset};
    r.data   = data;
    r.tag    = tag;
    return r;
  endfunction

  // model update in request order
  task automatic expect_result(input ls_req_t r);
    logic [31:0] addr;
    ls_rsp_t     e;
    addr  = r.base + {{16{r.offset[15]}}, r.offset};
    e.tag = r.tag;
    if (r.op == OP_STORE) begin
      model_mem[addr[11:2]] = r.data;
      e.data = r.data;  // store result echoes its data
    end else begin
      e.data = model_mem[addr[11:2]];
    end
    exp_q.push_back(e);
  endtask

  // entered on a falling edge, returns on the falling edge after the transfer
  task automatic send_req(input ls_req_t r);
    i_req_valid = 1'b1;
    i_req       = r;
    while (!o_req_ready) @(negedge clk);  // ready depends on DUT state only
    expect_result(r);
    @(negedge clk);
    i_req_valid = 1'b0;
  endtask

  task automatic start_test();
    test_errs = 0;
    tests_run++;
  endtask

  task automatic check_results(input string name);
    ls_rsp_t e;
    ls_rsp_t g;
    int      n;
    n = 0;
    while (got_q.size() < exp_q.size()) @(negedge clk);
    repeat (8) @(negedge clk);  // room for a surplus result to show up
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      g = got_q.pop_front();
      total_checks++;
      if (g.data !== e.data || g.tag !== e.tag) begin
        $display("Fail at %0t: %s result %0d expected data %h tag %h, got data %h tag %h",
                 $time, name, n, e.data, e.tag, g.data, g.tag);
        test_errs++;
      end
      n++;
    end
    if (got_q.size() != 0) begin
      $display("%s: %0d results came back with no request behind them", name, got_q.size());
      test_errs++;
      got_q.delete();
    end
    total_errs += test_errs;
    $display("%s: %0d results, %0d errors", name, n, test_errs);
  endtask

  task automatic test_cold_load();
    start_test();
    send_req(make_req(OP_LOAD, 700, '0, 4'h5));  // untouched word holds its index
    check_results("cold load");
  endtask

  task automatic test_forwarding();
    start_test();
    send_req(make_req(OP_STORE, 40, rand_bits(32), 4'h1));
    send_req(make_req(OP_LOAD, 40, '0, 4'h2));  // hits the queued store
    send_req(make_req(OP_LOAD, 41, '0, 4'h3));  // no match, memory word
    check_results("forwarding");
  endtask

  task automatic test_burst_order();
    start_test();
    for (int k = 0; k < 12; k++) begin
      send_req(make_req(rand_bits(1) ? OP_STORE : OP_LOAD, 48 + rand_bits(3),
                        rand_bits(32), 4'(k)));
    end
    check_results("burst order");
  endtask

  task automatic test_backpressure();
    ls_req_t req;
    ls_rsp_t held;
    logic    held_set;
    int      accepted;
    int      stalled;
    start_test();
    rsp_mode = RSP_OFF;
    held_set = 1'b0;
    accepted = 0;
    stalled  = 0;
    req      = make_req(OP_STORE, 64, rand_bits(32), 4'h0);
    while (stalled < 20) begin  // 20 refused cycles, queue is stuck full
      i_req_valid = 1'b1;
      i_req       = req;
      if (o_req_ready) begin
        expect_result(req);
        accepted++;
        stalled = 0;
        req = make_req(rand_bits(1) ? OP_STORE : OP_LOAD, 64 + rand_bits(4),
                       rand_bits(32), 4'(accepted));
      end else begin
        stalled++;
      end
      @(negedge clk);
      if (o_rsp_valid && !held_set) begin
        held     = o_rsp;
        held_set = 1'b1;
      end else if (held_set && (!o_rsp_valid || o_rsp !== held)) begin
        $display("Fail at %0t: held result %h became %h valid %b", $time, held, o_rsp,
                 o_rsp_valid);
        test_errs++;
      end
    end
    if (accepted != LSQ_DEPTH + 1) begin
      $display("Fail at %0t: o_req_ready dropped after %0d requests, expected %0d",
               $time, accepted, LSQ_DEPTH + 1);
      test_errs++;
    end
    if (!held_set) begin
      $display("back-pressure: no result was presented while the core held ready low");
      test_errs++;
    end
    rsp_mode = RSP_ON;
    send_req(req);  // the refused request enters once entries free up
    check_results("back-pressure");
  endtask

  task automatic test_random_mix();
    start_test();
    for (int i = 0; i < GAP_LEN; i++) begin
      gap_pat[i] = (rand_bits(2) != 0);  // ready about three cycles in four
    end
    rsp_mode = RSP_GAP;
    for (int k = 0; k < 200; k++) begin
      send_req(make_req(rand_bits(1) ? OP_STORE : OP_LOAD, rand_bits(5), rand_bits(32),
                        4'(rand_bits(4))));
      if (rand_bits(2) == 0) begin
        @(negedge clk);  // idle cycle
      end
    end
    check_results("random mix");
    rsp_mode = RSP_ON;
  endtask

  // result ready driver, records each result transfer
  always @(negedge clk) begin
    case (rsp_mode)
      RSP_OFF: i_rsp_ready = 1'b0;
      RSP_GAP: begin
        i_rsp_ready = gap_pat[gap_idx];
        gap_idx     = (gap_idx + 1) % GAP_LEN;
      end
      default: i_rsp_ready = 1'b1;
    endcase
    if (!rst && o_rsp_valid && i_rsp_ready) begin
      got_q.push_back(o_rsp);  // transfers on the coming rising edge
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run hit %0d cycles with results still outstanding", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    i_req_valid  = 1'b0;
    i_req        = '0;
    i_rsp_ready  = 1'b1;
    rsp_mode     = RSP_ON;
    gap_idx      = 0;
    cycles       = 0;
    lfsr_q       = SEED;
    tests_run    = 0;
    total_errs   = 0;
    total_checks = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = 32'(i);
    end
    @(negedge clk);
    while (rst) @(posedge clk);  // reset is stable at the rising edge
    @(negedge clk);
    test_cold_load();
    test_forwarding();
    test_burst_order();
    test_backpressure();
    test_random_mix();
    $display("%0d tests, %0d results checked, %0d errors", tests_run, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
verilog/lsq_pkg.sv
verilog/mem_pkg.sv
verilog/lsq_decode.sv
verilog/lsq_queue.sv
verilog/lsq_retire.sv
verilog/dcache_model.sv
verilog/lsq_top.sv
test/tb_clock.sv
test/lsq_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := lsq_tb
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
